// File: lock_pkg.sv
`default_nettype none

package lock_pkg;

	////////////////////////////////////////////////////////////
	// Basic widths
	////////////////////////////////////////////////////////////

	// One code digit
	typedef logic [3:0] digit_t;

	// Display glyph, 0 to 15 are the hex digits
	typedef logic [4:0] glyph_t;

	// d3 is the first digit entered
	typedef struct packed {
		digit_t d3;
		digit_t d2;
		digit_t d1;
		digit_t d0;
	} code_t;

	// Matches the board switches, tag on sw[7:4]
	typedef struct packed {
		digit_t tag;
		digit_t digit;
	} switch_t;

	// pos3 is the leftmost position
	typedef struct packed {
		glyph_t pos3;
		glyph_t pos2;
		glyph_t pos1;
		glyph_t pos0;
	} display_t;

	////////////////////////////////////////////////////////////
	// Named glyphs above the hex digits
	////////////////////////////////////////////////////////////

	localparam glyph_t G_BLANK = 5'd16;
	localparam glyph_t G_DASH  = 5'd17;
	localparam glyph_t G_C     = 5'd18;
	localparam glyph_t G_L     = 5'd19;
	localparam glyph_t G_S     = 5'd20;
	localparam glyph_t G_D     = 5'd21;
	localparam glyph_t G_O     = 5'd22;
	localparam glyph_t G_P     = 5'd23;
	localparam glyph_t G_E     = 5'd24;
	localparam glyph_t G_N     = 5'd25;
	localparam glyph_t G_V     = 5'd26;

	// Controller states, also driven out as the status code
	typedef enum logic [5:0] {
		ST_IDLE     = 6'd32,
		ST_DIGIT1   = 6'd1,
		ST_DIGIT2   = 6'd2,
		ST_DIGIT3   = 6'd3,
		ST_DIGIT4   = 6'd4,
		ST_CHECK    = 6'd11,
		ST_NEW1     = 6'd5,
		ST_NEW2     = 6'd6,
		ST_NEW3     = 6'd7,
		ST_NEW4     = 6'd8,
		ST_LOCKED   = 6'd9,
		ST_OPEN     = 6'd10,
		ST_BACKDOOR = 6'd12,
		ST_SCROLL1  = 6'd13,
		ST_SCROLL2  = 6'd14,
		ST_SCROLL3  = 6'd15,
		ST_SCROLL4  = 6'd16,
		ST_SCROLL5  = 6'd17,
		ST_SCROLL6  = 6'd18,
		ST_SCROLL7  = 6'd19,
		ST_SCROLL8  = 6'd20,
		ST_SCROLL9  = 6'd21,
		ST_SCROLL10 = 6'd22,
		ST_SCROLL11 = 6'd23,
		ST_SCROLL12 = 6'd24,
		ST_SCROLL13 = 6'd25,
		ST_SCROLL14 = 6'd26,
		ST_SCROLL15 = 6'd27,
		ST_SCROLL16 = 6'd28
	} lock_state_t;

	// Service backdoor
	localparam digit_t SERVICE_TAG = 4'hA;

	localparam code_t RESET_CODE   = 16'h0000;
	localparam code_t SERVICE_CODE = 16'h0311;

endpackage

`default_nettype wire

// File: lock_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module lock_fsm
	import lock_pkg::*;
#(
	parameter int STEP_CYCLES      = 14,
	parameter int BACKDOOR_PRESSES = 5
)
(
	input  wire               clk,
	input  wire               rst,
	input  wire               ent,
	input  wire               clr,
	input  wire               change,
	input  wire switch_t      sw,
	input  wire               match,
	output lock_state_t       state
);

	localparam int STEP_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
	localparam int TAG_W  = $clog2(BACKDOOR_PRESSES + 1);

	lock_state_t       next_state;
	logic              lock_mode;
	logic [TAG_W-1:0]  tag_cnt;
	logic [STEP_W-1:0] step_cnt;
	logic              tag_hit;
	logic              bd_armed;
	logic              bd_allowed;
	logic              in_scroll;
	logic              step_done;

	assign tag_hit    = (sw.tag == SERVICE_TAG);
	assign bd_armed   = (tag_cnt == TAG_W'(BACKDOOR_PRESSES));
	assign in_scroll  = state inside {[ST_SCROLL1:ST_SCROLL16]};
	assign step_done  = (step_cnt == STEP_W'(STEP_CYCLES - 1));
	// No backdoor from check or while the message runs
	assign bd_allowed = state inside {ST_IDLE, [ST_DIGIT1:ST_DIGIT4], [ST_NEW1:ST_NEW4],
		ST_LOCKED, ST_OPEN};

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE, ST_LOCKED:
			begin
				if (ent || clr)
					next_state = ST_DIGIT1;
			end
			ST_DIGIT1, ST_DIGIT2, ST_DIGIT3:
			begin
				if (ent)
					next_state = lock_state_t'(state + 6'd1);
				else if (clr)
					next_state = ST_DIGIT1;
			end
			ST_DIGIT4:
			begin
				if (ent)
					next_state = ST_CHECK;
				else if (clr)
					next_state = ST_DIGIT1;
			end
			ST_CHECK:
			begin
				// Good code flips the mode, bad code keeps it
				if (match == lock_mode)
					next_state = ST_OPEN;
				else
					next_state = ST_LOCKED;
			end
			ST_NEW1, ST_NEW2, ST_NEW3:
			begin
				if (ent)
					next_state = lock_state_t'(state + 6'd1);
				else if (clr)
					next_state = ST_NEW1;
			end
			ST_NEW4:
			begin
				if (ent)
					next_state = ST_OPEN;
				else if (clr)
					next_state = ST_NEW1;
			end
			ST_OPEN:
			begin
				if (ent)
					next_state = ST_DIGIT1;
				else if (change)
					next_state = ST_NEW1;
			end
			ST_BACKDOOR:
				next_state = ST_SCROLL1;
			default:
			begin
				if (!in_scroll)
					next_state = ST_IDLE;
				else if (step_done && state == ST_SCROLL16)
					next_state = ST_LOCKED;
				else if (step_done)
					next_state = lock_state_t'(state + 6'd1);
			end
		endcase

		// Armed backdoor overrides the normal move
		if (ent && bd_armed && bd_allowed)
			next_state = ST_BACKDOOR;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	////////////////////////////////////////////////////////////
	// Lock mode, tag presses and scroll timing
	////////////////////////////////////////////////////////////

	// 1 means locked
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			lock_mode <= 1'b1;
		else if (state == ST_LOCKED)
			lock_mode <= 1'b1;
		else if (state == ST_OPEN)
			lock_mode <= 1'b0;
		else if (state == ST_CHECK && match)
			lock_mode <= ~lock_mode;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			tag_cnt <= '0;
		else if (state == ST_BACKDOOR)
			tag_cnt <= '0;
		else if (ent)
		begin
			if (!tag_hit)
				tag_cnt <= '0;
			else if (!bd_armed)
				tag_cnt <= tag_cnt + 1'b1;
		end
		else if (!tag_hit && (state == ST_LOCKED || state == ST_OPEN))
			tag_cnt <= '0;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			step_cnt <= '0;
		else if (!in_scroll || step_done)
			step_cnt <= '0;
		else
			step_cnt <= step_cnt + 1'b1;
	end

endmodule

`default_nettype wire

// File: code_store.sv
`timescale 1ns/10ps
`default_nettype none

module code_store
	import lock_pkg::*;
(
	input  wire               clk,
	input  wire               rst,
	input  wire               ent,
	input  wire switch_t      sw,
	input  wire lock_state_t  state,
	output code_t             stored,
	output logic              match
);

	code_t entered;

	// Digits typed for a check
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			entered <= '0;
		else if (ent)
		begin
			case (state)
				ST_DIGIT1: entered.d3 <= sw.digit;
				ST_DIGIT2: entered.d2 <= sw.digit;
				ST_DIGIT3: entered.d1 <= sw.digit;
				ST_DIGIT4: entered.d0 <= sw.digit;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Stored code
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			stored <= RESET_CODE;
		else if (state == ST_IDLE)
			stored <= RESET_CODE;
		else if (state == ST_BACKDOOR)
			stored <= SERVICE_CODE;
		else if (ent)
		begin
			case (state)
				ST_NEW1: stored.d3 <= sw.digit;
				ST_NEW2: stored.d2 <= sw.digit;
				ST_NEW3: stored.d1 <= sw.digit;
				ST_NEW4: stored.d0 <= sw.digit;
				default: ;
			endcase
		end
	end

	assign match = (entered == stored);

endmodule

`default_nettype wire

// File: display_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module display_encoder
	import lock_pkg::*;
(
	input  wire               clk,
	input  wire               rst,
	input  wire lock_state_t  state,
	input  wire switch_t      sw,
	input  wire code_t        stored,
	output display_t          display
);

	localparam display_t DISP_CLSD = {G_C, G_L, G_S, G_D};
	localparam display_t DISP_OPEN = {G_O, G_P, G_E, G_N};

	// Digit glyphs used by the message
	localparam glyph_t G_ONE   = 5'd1;
	localparam glyph_t G_THREE = 5'd3;
	localparam glyph_t B       = G_BLANK;

	glyph_t live;
	glyph_t s3;
	glyph_t s2;
	glyph_t s1;

	assign live = {1'b0, sw.digit};
	assign s3   = {1'b0, stored.d3};
	assign s2   = {1'b0, stored.d2};
	assign s1   = {1'b0, stored.d1};

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			display <= DISP_CLSD;
		else
		begin
			case (state)
				ST_IDLE, ST_LOCKED: display <= DISP_CLSD;
				ST_OPEN:            display <= DISP_OPEN;

				////////////////////////////////////////////////////////////
				// Code entry, dashes for digits already taken
				////////////////////////////////////////////////////////////
				ST_DIGIT1: display <= {live, B, B, B};
				ST_DIGIT2: display <= {G_DASH, live, B, B};
				ST_DIGIT3: display <= {G_DASH, G_DASH, live, B};
				ST_DIGIT4: display <= {G_DASH, G_DASH, G_DASH, live};

				// New code echoes what is already stored
				ST_NEW1: display <= {live, B, B, B};
				ST_NEW2: display <= {s3, live, B, B};
				ST_NEW3: display <= {s3, s2, live, B};
				ST_NEW4: display <= {s3, s2, s1, live};

				////////////////////////////////////////////////////////////
				// Service message "1 LOVE EC311" moving left
				////////////////////////////////////////////////////////////
				ST_SCROLL1:  display <= {B, B, B, B};
				ST_SCROLL2:  display <= {B, B, B, G_ONE};
				ST_SCROLL3:  display <= {B, B, G_ONE, B};
				ST_SCROLL4:  display <= {B, G_ONE, B, G_L};
				ST_SCROLL5:  display <= {G_ONE, B, G_L, G_O};
				ST_SCROLL6:  display <= {B, G_L, G_O, G_V};
				ST_SCROLL7:  display <= {G_L, G_O, G_V, G_E};
				ST_SCROLL8:  display <= {G_O, G_V, G_E, B};
				ST_SCROLL9:  display <= {G_V, G_E, B, G_E};
				ST_SCROLL10: display <= {G_E, B, G_E, G_C};
				ST_SCROLL11: display <= {B, G_E, G_C, G_THREE};
				ST_SCROLL12: display <= {G_E, G_C, G_THREE, G_ONE};
				ST_SCROLL13: display <= {G_C, G_THREE, G_ONE, G_ONE};
				ST_SCROLL14: display <= {G_THREE, G_ONE, G_ONE, B};
				ST_SCROLL15: display <= {G_ONE, G_ONE, B, B};
				// Last step clears the tail in one go
				ST_SCROLL16: display <= {B, B, B, B};

				// Check and backdoor keep the last frame
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: lock_top.sv
`timescale 1ns/10ps
`default_nettype none

module lock_top
	import lock_pkg::*;
#(
	parameter int STEP_CYCLES      = 14,
	parameter int BACKDOOR_PRESSES = 5
)
(
	input  wire               clk,
	input  wire               rst,
	input  wire               ent,
	input  wire               clr,
	input  wire               change,
	input  wire switch_t      sw,
	output lock_state_t       status,
	output display_t          display
);

	lock_state_t state;
	code_t       stored;
	logic        match;

	// Controller decides every move
	lock_fsm #(
		.STEP_CYCLES      (STEP_CYCLES),
		.BACKDOOR_PRESSES (BACKDOOR_PRESSES)
	) u_fsm (
		.clk    (clk),
		.rst    (rst),
		.ent    (ent),
		.clr    (clr),
		.change (change),
		.sw     (sw),
		.match  (match),
		.state  (state)
	);

	code_store u_code (
		.clk    (clk),
		.rst    (rst),
		.ent    (ent),
		.sw     (sw),
		.state  (state),
		.stored (stored),
		.match  (match)
	);

	// One cycle behind the state
	display_encoder u_disp (
		.clk     (clk),
		.rst     (rst),
		.state   (state),
		.sw      (sw),
		.stored  (stored),
		.display (display)
	);

	assign status = state;

endmodule

`default_nettype wire

// File: lock_checker.sv
`timescale 1ns/10ps
`default_nettype none

module lock_checker
	import lock_pkg::*;
(
	input wire              clk,
	input wire              rst,
	input wire lock_state_t status
);

	// Failed assertions so far
	int unsigned fails = 0;

	////////////////////////////////////////////////////////////
	// Controller sequencing
	////////////////////////////////////////////////////////////

	// Code check resolves after one cycle
	a_check_resolves: assert property (@(posedge clk) disable iff (rst)
		status == ST_CHECK |=> (status == ST_OPEN || status == ST_LOCKED))
	else
	begin
		$error("check state did not move to open or locked");
		fails++;
	end

	// Message always ends locked
	a_scroll_ends_locked: assert property (@(posedge clk) disable iff (rst)
		status == ST_SCROLL16 |=> (status == ST_SCROLL16 || status == ST_LOCKED))
	else
	begin
		$error("last scroll state did not end in locked");
		fails++;
	end

	a_status_legal: assert property (@(posedge clk) disable iff (rst)
		status inside {ST_IDLE, [ST_DIGIT1:ST_SCROLL16]})
	else
	begin
		$error("status left the defined state codes");
		fails++;
	end

endmodule

bind lock_top lock_checker u_checker (
	.clk    (clk),
	.rst    (rst),
	.status (status)
);

`default_nettype wire

// File: lock_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lock_tb
	import lock_pkg::*;
();

	localparam int STEP_CYCLES  = 4;
	localparam int BACKDOOR_LEN = 1 + 16 * STEP_CYCLES;

	// One row of the data file
	typedef struct packed {
		logic [47:0] cmd;
		switch_t     sw;
		logic [5:0]  status;
		display_t    display;
	} step_t;

	// All glyphs at 31 ask for the scroll frames
	localparam display_t FRAMES_MARK = '1;

	logic        clk = 1'b0;
	logic        rst;
	logic        ent;
	logic        clr;
	logic        change;
	switch_t     sw;
	lock_state_t status;
	display_t    display;

	step_t       step_q[$];
	int          errors;
	int          checks;
	int          assert_fails;
	int          cycles = 0;
	int          cycle_limit = 1000;

	lock_top #(
		.STEP_CYCLES (STEP_CYCLES)
	) dut0 (
		.clk     (clk),
		.rst     (rst),
		.ent     (ent),
		.clr     (clr),
		.change  (change),
		.sw      (sw),
		.status  (status),
		.display (display)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("timeout after %0d cycles, the DUT never reached the expected state", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and expected frames
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	function automatic glyph_t msg_glyph(input byte c);
		case (c)
			"1": return 5'd1;
			"3": return 5'd3;
			"L": return G_L;
			"O": return G_O;
			"V": return G_V;
			"E": return G_E;
			"C": return G_C;
			default: return G_BLANK;
		endcase
	endfunction

	// Four-glyph window of the padded message
	// Frame 16 is all blanks
	function automatic display_t scroll_frame(input int k);
		string    msg = "    1 LOVE EC311    ";
		display_t frame;
		frame = {G_BLANK, G_BLANK, G_BLANK, G_BLANK};
		if (k < 16)
			frame = {msg_glyph(msg[k-1]), msg_glyph(msg[k]),
				msg_glyph(msg[k+1]), msg_glyph(msg[k+2])};
		return frame;
	endfunction

	////////////////////////////////////////////////////////////
	// Data file and step execution
	////////////////////////////////////////////////////////////

	task automatic read_steps();
		int               fd;
		int               n;
		logic [8*128-1:0] line;
		logic [47:0]      cmd;
		logic [7:0]       swv;
		int               st;
		int               g3, g2, g1, g0;
		step_t            s;
		fd = $fopen("lock_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open lock_testdata.txt");
			errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = '0;
			cmd = '0;
			n = $fgets(line, fd);
			n = $sscanf(line, "%s %h %d %d %d %d %d", cmd, swv, st, g3, g2, g1, g0);
			if (n == 7)
			begin
				s.cmd = cmd;
				s.sw = switch_t'(swv);
				s.status = 6'(st);
				s.display = {5'(g3), 5'(g2), 5'(g1), 5'(g0)};
				step_q.push_back(s);
			end
			else if (n > 0 && cmd != "//")
			begin
				$display("a line of lock_testdata.txt could not be read");
				errors++;
			end
		end
		$fclose(fd);
	endtask

	// One display check per scroll state, then the run length
	task automatic check_frames(input step_t s);
		lock_state_t target;
		int          k;
		int          start;
		start = cycles;
		if (s.sw.tag != SERVICE_TAG)
		begin
			$display("the backdoor step does not carry the service tag");
			errors++;
		end
		for (k = 1; k <= 16; k++)
		begin
			target = lock_state_t'(ST_SCROLL1 + k - 1);
			while (status != target)
				@(negedge clk);
			@(negedge clk);
			check_value("display", display, scroll_frame(k));
		end
		// Trigger enter up to the first locked cycle
		while (status != lock_state_t'(s.status))
			@(negedge clk);
		check_value("backdoor cycles", cycles - start, BACKDOOR_LEN);
		check_value("stored code", dut0.u_code.stored, SERVICE_CODE);
	endtask

	task automatic run_step(input step_t s);
		sw = s.sw;
		case (s.cmd)
			"enter":  ent = 1'b1;
			"clear":  clr = 1'b1;
			"change": change = 1'b1;
			"settle": ;
			default:
			begin
				$display("unknown command in lock_testdata.txt");
				errors++;
			end
		endcase
		@(negedge clk);
		ent = 1'b0;
		clr = 1'b0;
		change = 1'b0;
		if (s.display == FRAMES_MARK)
			check_frames(s);
		else
		begin
			repeat (3) @(negedge clk);
			check_value("status", status, s.status);
			check_value("display", display, s.display);
		end
	endtask

	initial
	begin
		rst = 1'b1;
		ent = 1'b0;
		clr = 1'b0;
		change = 1'b0;
		sw = '0;
		errors = 0;
		checks = 0;
		read_steps();
		cycle_limit = 2 * step_q.size() * 4 + BACKDOOR_LEN;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		check_value("stored code", dut0.u_code.stored, RESET_CODE);
		foreach (step_q[i])
			run_step(step_q[i]);
		assert_fails = int'(dut0.u_checker.fails);
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: lock_testdata.txt
// cmd sw(hex) status(dec) glyphs pos3..pos0 (dec), glyphs 31 31 31 31 check the scroll frames
// Glyphs 0-15 hex digit, 16 blank, 17 dash, 18 C, 19 L, 20 S, 21 D, 22 O, 23 P, 24 E, 25 N
// Status 32 idle, 1-4 digit, 5-8 new code, 9 locked, 10 open
settle  00  32  18 19 20 21
enter   00   1   0 16 16 16
enter   00   2  17  0 16 16
enter   00   3  17 17  0 16
enter   00   4  17 17 17  0
enter   00  10  22 23 24 25
enter   00   1   0 16 16 16
enter   00   2  17  0 16 16
enter   00   3  17 17  0 16
enter   00   4  17 17 17  0
enter   00   9  18 19 20 21
enter   05   1   5 16 16 16
enter   05   2  17  5 16 16
enter   06   3  17 17  6 16
clear   06   1   6 16 16 16
enter   00   2  17  0 16 16
enter   00   3  17 17  0 16
enter   00   4  17 17 17  0
enter   00  10  22 23 24 25
change  07   5   7 16 16 16
enter   07   6   7  7 16 16
enter   02   7   7  2  2 16
enter   09   8   7  2  9  9
enter   04  10  22 23 24 25
enter   07   1   7 16 16 16
enter   07   2  17  7 16 16
enter   02   3  17 17  2 16
enter   09   4  17 17 17  9
enter   04   9  18 19 20 21
enter   00   1   0 16 16 16
enter   00   2  17  0 16 16
enter   00   3  17 17  0 16
enter   00   4  17 17 17  0
enter   00   9  18 19 20 21
enter   a5   1   5 16 16 16
enter   a5   2  17  5 16 16
enter   a5   3  17 17  5 16
enter   a5   4  17 17 17  5
enter   a5   9  18 19 20 21
enter   a5   9  31 31 31 31
settle  00   9  18 19 20 21
enter   00   1   0 16 16 16
enter   00   2  17  0 16 16
enter   03   3  17 17  3 16
enter   01   4  17 17 17  1
enter   01  10  22 23 24 25

// File: sim.f
lock_pkg.sv
lock_fsm.sv
code_store.sv
display_encoder.sv
lock_top.sv
lock_checker.sv
lock_tb.sv

// File: run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module lock_tb
./obj_dir/Vlock_tb +verilator+error+limit+100 | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
	exit 0
fi
exit 1
